//--- ipod.f
source/ipod_pkg.sv
source/speed_ctrl.sv
source/sample_timer.sv
source/phoneme_player.sv
source/volume_meter.sv
source/ipod_top.sv
sim/flash_model.sv
sim/tb_ipod.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_ipod
FILELIST   = ipod.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = >>> PASS

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/ipod_trace.txt
# Columns: name command p1 p2 p3 p4
# reset/hold/release: p1 key (0 up, 1 down, 2 reset), p2 cycles, p4 divisor
# play: p1 phoneme, p2 start word, p3 sample count, p4 silent flag
after_reset reset 0 8 0 6944
phoneme1 play 1 16 12 0
reset_again reset 0 8 0 6944
silent0 play 0 0 16 1
volume2 play 2 64 24 0
volume3 play 3 200 8 0
speed_up hold 0 503 0 6752
up_release release 0 8 0 6752
speed_down hold 1 43000 0 20000
down_release release 0 8 0 20000
speed_reset hold 2 10 0 6944
reset_release release 0 8 0 6944

//--- sim/tb_ipod.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ipod;
  import ipod_pkg::*;

  logic                       CLK_50M = 1'b0;
  logic                       rst_n;
  logic                       key_up;
  logic                       key_down;
  logic                       key_reset;
  logic                       play;
  logic [PHONEME_W-1:0]       phoneme;
  flash_req_t                 flash_req;
  flash_rsp_t                 flash_rsp;
  logic signed [SAMPLE_W-1:0] sample;
  logic                       sample_valid;
  logic                       busy;
  logic                       done;
  logic [LED_W-1:0]           leds;
  logic [DIV_W-1:0]           divisor;

  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  // Divisor expected from the last key or reset step
  int         exp_divisor = int'(SPEED_DEFAULT);
  // Reference volume meter
  int         vol_sum;
  int         vol_count;
  logic [7:0] exp_leds;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top #(
    .repeat_cycles (200)
  ) uut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key_up       (key_up),
    .key_down     (key_down),
    .key_reset    (key_reset),
    .play         (play),
    .phoneme      (phoneme),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .busy         (busy),
    .done         (done),
    .leds         (leds),
    .divisor      (divisor)
  );

  flash_model u_flash (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  task automatic compare_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("** Error %s: %s expected %0d, actual %0d", name, what, expected, actual);
      errors++;
    end
  endtask

  // Magnitude sum over 16 samples, shifted by 8, gives the LED count
  task automatic track_volume(input logic [7:0] value);
    int lvl;
    vol_sum += value[7] ? 256 - int'(value) : int'(value);
    vol_count++;
    if (vol_count == VOL_BLOCK)
    begin
      lvl       = vol_sum >> 8;
      exp_leds  = 8'((1 << lvl) - 1);
      vol_sum   = 0;
      vol_count = 0;
    end
  endtask

  task automatic apply_reset(input string name, input int cycles, input int exp_div);
    @(negedge CLK_50M);
    rst_n     = 1'b0;
    key_up    = 1'b0;
    key_down  = 1'b0;
    key_reset = 1'b0;
    play      = 1'b0;
    repeat (cycles) @(negedge CLK_50M);
    rst_n       = 1'b1;
    vol_sum     = 0;
    vol_count   = 0;
    exp_leds    = '0;
    exp_divisor = exp_div;
    compare_value(name, "divisor", 32'(exp_div), divisor);
    compare_value(name, "busy", 32'd0, 32'(busy));
    compare_value(name, "leds", 32'd0, 32'(leds));
    compare_value(name, "flash read", 32'd0, 32'(flash_req.read));
    compare_value(name, "sample_valid", 32'd0, 32'(sample_valid));
    compare_value(name, "sample", 32'd0, 32'($unsigned(sample)));
    compare_value(name, "done", 32'd0, 32'(done));
  endtask

  // ==========================================================
  // Playback with sample, spacing and volume checks
  // ==========================================================
  task automatic run_play(input string name, input int ph, input int start, input int n,
                          input int silent, output bit timed_out);
    int         got;
    int         cycles;
    int         last_cycle;
    int         reads;
    int         limit;
    bit         finished;
    logic [7:0] expv;
    got        = 0;
    cycles     = 0;
    last_cycle = 0;
    reads      = 0;
    finished   = 1'b0;
    limit      = (n + 4) * int'(SPEED_MAX);
    @(negedge CLK_50M);
    phoneme = PHONEME_W'(ph);
    play    = 1'b1;
    @(negedge CLK_50M);
    play = 1'b0;
    compare_value(name, "busy after play", 32'd1, 32'(busy));
    while (!finished && cycles < limit)
    begin
      if (flash_req.read)
        reads++;
      if (sample_valid)
      begin
        expv = (silent != 0) ? 8'd0 : 8'(4 * start + got);
        if (got < n)
          compare_value(name, "sample", 32'(expv), 32'($unsigned(sample)));
        if (got > 0)
          compare_value(name, "sample spacing", 32'(exp_divisor), 32'(cycles - last_cycle));
        last_cycle = cycles;
        got++;
        track_volume(expv);
      end
      if (done)
        finished = 1'b1;
      else
      begin
        @(negedge CLK_50M);
        cycles++;
      end
    end
    timed_out = !finished;
    if (timed_out)
    begin
      $display("Test %s timed out waiting for done after %0d cycles", name, cycles);
      errors++;
    end
    else
    begin
      compare_value(name, "sample count", 32'(n), 32'(got));
      compare_value(name, "busy at done", 32'd0, 32'(busy));
      compare_value(name, "leds", 32'(exp_leds), 32'(leds));
      if (silent != 0)
        compare_value(name, "flash reads", 32'd0, 32'(reads));
      @(negedge CLK_50M);
      compare_value(name, "done width", 32'd0, 32'(done));
    end
  endtask

  // Key code 0 up, 1 down, 2 reset
  task automatic hold_key(input string name, input int key, input int cycles, input int exp_div);
    @(negedge CLK_50M);
    key_up    = (key == 0);
    key_down  = (key == 1);
    key_reset = (key == 2);
    repeat (cycles) @(negedge CLK_50M);
    exp_divisor = exp_div;
    compare_value(name, "divisor", 32'(exp_div), divisor);
  endtask

  task automatic release_keys(input string name, input int cycles, input int exp_div);
    @(negedge CLK_50M);
    key_up    = 1'b0;
    key_down  = 1'b0;
    key_reset = 1'b0;
    repeat (cycles) @(negedge CLK_50M);
    exp_divisor = exp_div;
    compare_value(name, "divisor", 32'(exp_div), divisor);
  endtask

  initial
  begin
    int    fd;
    int    status;
    int    fields;
    int    errors_before;
    int    p1;
    int    p2;
    int    p3;
    int    p4;
    string line;
    string name;
    string cmd;
    bit    aborted;
    rst_n     = 1'b0;
    key_up    = 1'b0;
    key_down  = 1'b0;
    key_reset = 1'b0;
    play      = 1'b0;
    phoneme   = '0;
    aborted   = 1'b0;
    fd = $fopen("sim/ipod_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file sim/ipod_trace.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd) && !aborted)
      begin
        line   = "";
        status = $fgets(line, fd);
        if (status != 0 && line.len() > 1 && line[0] != "#")
        begin
          fields = $sscanf(line, "%s %s %d %d %d %d", name, cmd, p1, p2, p3, p4);
          errors_before = errors;
          tests_run++;
          if (fields != 6)
          begin
            $display("Trace line is malformed: %s", line);
            errors++;
          end
          else if (cmd == "reset")
            apply_reset(name, p2, p4);
          else if (cmd == "play")
            run_play(name, p1, p2, p3, p4, aborted);
          else if (cmd == "hold")
            hold_key(name, p1, p2, p4);
          else if (cmd == "release")
            release_keys(name, p2, p4);
          else
          begin
            $display("Unknown trace command %s in test %s", cmd, name);
            errors++;
          end
          if (errors == errors_before)
            $display("Test %s passed", name);
          else
          begin
            $display("Test %s failed", name);
            tests_failed++;
          end
        end
      end
      $fclose(fd);
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/flash_model.sv
`timescale 1ns/100ps
`default_nettype none

module flash_model (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::flash_rsp_t flash_rsp
);
  import ipod_pkg::*;

  logic [31:0]       rng;
  logic [2:0]        delay;
  logic              pending;
  logic [ADDR_W-1:0] addr_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte k of word w holds the low bits of 4w+k
  function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] w);
    logic [WORD_W-1:0] data;
    data = '0;
    for (int k = 0; k < SAMPLES_PER_WORD; k++)
      data[8*k +: 8] = 8'(4 * int'(w) + k);
    return data;
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rng       <= 32'h6f73;
      flash_rsp <= '0;
      pending   <= 1'b0;
      delay     <= 3'd0;
      addr_q    <= '0;
    end
    else
    begin
      rng <= xorshift(rng);
      flash_rsp.readdatavalid <= 1'b0;
      // Waitrequest high about one cycle in four
      flash_rsp.waitrequest <= (rng[3:2] == 2'b11);
      if (pending)
      begin
        if (delay == 3'd1)
        begin
          flash_rsp.readdatavalid <= 1'b1;
          flash_rsp.readdata      <= word_at(addr_q);
          pending                 <= 1'b0;
        end
        else
          delay <= delay - 3'd1;
      end
      else if (flash_req.read && !flash_rsp.waitrequest)
      begin
        pending <= 1'b1;
        addr_q  <= flash_req.address;
        delay   <= 3'(rng[1:0]) + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ipod_top.sv
`timescale 1ns/100ps
`default_nettype none

module ipod_top #(
  parameter int repeat_cycles = ipod_pkg::REPEAT_CYCLES
) (
  input  logic                                 CLK_50M,
  input  logic                                 rst_n,
  input  logic                                 key_up,
  input  logic                                 key_down,
  input  logic                                 key_reset,
  input  logic                                 play,
  input  logic [ipod_pkg::PHONEME_W-1:0]       phoneme,
  output ipod_pkg::flash_req_t                 flash_req,
  input  ipod_pkg::flash_rsp_t                 flash_rsp,
  output logic signed [ipod_pkg::SAMPLE_W-1:0] sample,
  output logic                                 sample_valid,
  output logic                                 busy,
  output logic                                 done,
  output logic [ipod_pkg::LED_W-1:0]           leds,
  output logic [ipod_pkg::DIV_W-1:0]           divisor
);

  logic sample_tick;

  // Key levels to divisor
  speed_ctrl #(
    .repeat_cycles (repeat_cycles)
  ) u_speed_ctrl (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .key_up    (key_up),
    .key_down  (key_down),
    .key_reset (key_reset),
    .divisor   (divisor)
  );

  sample_timer u_sample_timer (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .divisor     (divisor),
    .sample_tick (sample_tick)
  );

  phoneme_player u_phoneme_player (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .play         (play),
    .phoneme      (phoneme),
    .sample_tick  (sample_tick),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .busy         (busy),
    .done         (done)
  );

  volume_meter u_volume_meter (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .leds         (leds)
  );

endmodule

`default_nettype wire

//--- source/volume_meter.sv
`timescale 1ns/100ps
`default_nettype none

module volume_meter (
  input  logic                                 CLK_50M,
  input  logic                                 rst_n,
  input  logic signed [ipod_pkg::SAMPLE_W-1:0] sample,
  input  logic                                 sample_valid,
  output logic [ipod_pkg::LED_W-1:0]           leds
);
  import ipod_pkg::*;

  localparam int CNT_W     = $clog2(VOL_BLOCK);
  localparam int SUM_W     = SAMPLE_W + CNT_W;
  // Block average, then four more bits down to 0..8 LEDs
  localparam int LVL_SHIFT = CNT_W + 4;

  logic [SAMPLE_W-1:0] magnitude;
  logic [SUM_W-1:0]    sum;
  logic [SUM_W-1:0]    block_total;
  logic [SUM_W-1:0]    level;
  logic [CNT_W-1:0]    count;
  logic [LED_W-1:0]    bar;

  // Negative full scale wraps to 8'h80, which reads as 128
  assign magnitude   = sample[SAMPLE_W-1] ? -sample : sample;
  assign block_total = sum + SUM_W'(magnitude);
  assign level       = block_total >> LVL_SHIFT;

  always_comb
  begin
    for (int i = 0; i < LED_W; i++)
      bar[i] = (level > SUM_W'(i));
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sum   <= '0;
      count <= '0;
      leds  <= '0;
    end
    else if (sample_valid)
    begin
      if (count == CNT_W'(VOL_BLOCK - 1))
      begin
        sum   <= '0;
        count <= '0;
        leds  <= bar;
      end
      else
      begin
        sum   <= block_total;
        count <= count + 1'b1;
      end
    end
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (leds & (leds + 1'b1)) == '0);

endmodule

`default_nettype wire

//--- source/phoneme_player.sv
`timescale 1ns/100ps
`default_nettype none

module phoneme_player (
  input  logic                                 CLK_50M,
  input  logic                                 rst_n,
  input  logic                                 play,
  input  logic [ipod_pkg::PHONEME_W-1:0]       phoneme,
  input  logic                                 sample_tick,
  output ipod_pkg::flash_req_t                 flash_req,
  input  ipod_pkg::flash_rsp_t                 flash_rsp,
  output logic signed [ipod_pkg::SAMPLE_W-1:0] sample,
  output logic                                 sample_valid,
  output logic                                 busy,
  output logic                                 done
);
  import ipod_pkg::*;

  localparam logic [1:0] LAST_IDX = 2'(SAMPLES_PER_WORD - 1);

  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    WAIT_DATA,
    PLAY,
    FINISH
  } state_t;

  state_t            state;
  phoneme_entry_t    entry;
  logic [ADDR_W-1:0] word_addr;
  logic [7:0]        words_left;
  logic [1:0]        sample_idx;
  logic              silent;
  logic              start;
  sample_word_u      word_buf;

  assign entry = PHONEME_TABLE[phoneme];
  // Strobes while busy are dropped
  assign start = play && (state == IDLE || state == FINISH);

  // ==========================================================
  // Playback FSM
  // ==========================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      word_addr  <= '0;
      words_left <= '0;
      sample_idx <= '0;
      silent     <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE, FINISH:
        begin
          if (start)
          begin
            word_addr  <= entry.start_addr;
            words_left <= entry.word_count;
            silent     <= entry.silent;
            sample_idx <= '0;
            state      <= entry.silent ? PLAY : REQUEST;
          end
          else
            state <= IDLE;
        end
        REQUEST:
        begin
          if (!flash_rsp.waitrequest)
            state <= WAIT_DATA;
        end
        WAIT_DATA:
        begin
          if (flash_rsp.readdatavalid)
            state <= PLAY;
        end
        PLAY:
        begin
          if (sample_tick)
          begin
            sample_idx <= sample_idx + 1'b1;
            if (sample_idx == LAST_IDX)
            begin
              if (words_left == 8'd1)
                state <= FINISH;
              else
              begin
                words_left <= words_left - 1'b1;
                word_addr  <= word_addr + 1'b1;
                state      <= silent ? PLAY : REQUEST;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Silent phonemes play from a cleared word
  always_ff @(posedge CLK_50M)
  begin
    if (start)
      word_buf.word <= '0;
    else if (state == WAIT_DATA && flash_rsp.readdatavalid)
      word_buf.word <= flash_rsp.readdata;
  end

  assign flash_req    = '{read: (state == REQUEST), address: word_addr};
  assign sample_valid = (state == PLAY) && sample_tick;
  assign sample       = sample_valid ? word_buf.samples[sample_idx] : '0;
  assign busy         = (state == REQUEST) || (state == WAIT_DATA) || (state == PLAY);
  assign done         = (state == FINISH);

  // Pending request keeps its address until the flash takes it
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address));

endmodule

`default_nettype wire

//--- source/sample_timer.sv
`timescale 1ns/100ps
`default_nettype none

module sample_timer (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic [ipod_pkg::DIV_W-1:0] divisor,
  output logic                       sample_tick
);
  import ipod_pkg::*;

  logic [DIV_W-1:0] count;
  // Period in force until the next wrap
  logic [DIV_W-1:0] period;

  assign sample_tick = (count == period);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count  <= DIV_W'(1);
      period <= SPEED_DEFAULT;
    end
    else if (sample_tick)
    begin
      count  <= DIV_W'(1);
      period <= divisor;
    end
    else
      count <= count + 1'b1;
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_tick |=> !sample_tick);

endmodule

`default_nettype wire

//--- source/speed_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module speed_ctrl #(
  parameter int repeat_cycles = ipod_pkg::REPEAT_CYCLES
) (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic                       key_up,
  input  logic                       key_down,
  input  logic                       key_reset,
  output logic [ipod_pkg::DIV_W-1:0] divisor
);
  import ipod_pkg::*;

  localparam int RPT_W = (repeat_cycles > 1) ? $clog2(repeat_cycles) : 1;

  // Bit 0 up, bit 1 down, bit 2 reset
  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [RPT_W-1:0] rpt_cnt;
  logic             step_up;
  logic             step_down;
  logic             any_step_key;

  assign any_step_key = key_sync[0] || key_sync[1];

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta  <= '0;
      key_sync  <= '0;
      rpt_cnt   <= '0;
      step_up   <= 1'b0;
      step_down <= 1'b0;
    end
    else
    begin
      key_meta <= {key_reset, key_down, key_up};
      key_sync <= key_meta;
      // Held key steps at count zero, then once per repeat period
      if (!any_step_key || rpt_cnt == RPT_W'(repeat_cycles - 1))
        rpt_cnt <= '0;
      else
        rpt_cnt <= rpt_cnt + 1'b1;
      step_up   <= key_sync[0] && !key_sync[1] && rpt_cnt == '0;
      step_down <= key_sync[1] && !key_sync[0] && rpt_cnt == '0;
    end
  end

  // Clamped divisor, reset key wins
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || key_sync[2])
      divisor <= SPEED_DEFAULT;
    else if (step_up)
      divisor <= (divisor <= SPEED_MIN + SPEED_STEP) ? SPEED_MIN : divisor - SPEED_STEP;
    else if (step_down)
      divisor <= (divisor >= SPEED_MAX - SPEED_STEP) ? SPEED_MAX : divisor + SPEED_STEP;
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    divisor >= SPEED_MIN && divisor <= SPEED_MAX);

endmodule

`default_nettype wire

//--- source/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ==========================================================
  // Widths
  // ==========================================================
  localparam int SAMPLE_W         = 8;
  localparam int WORD_W           = 32;
  localparam int ADDR_W           = 23;
  localparam int SAMPLES_PER_WORD = 4;
  localparam int DIV_W            = 32;
  localparam int PHONEME_W        = 2;
  localparam int LED_W            = 8;

  // Samples per volume average
  localparam int VOL_BLOCK = 16;

  // ==========================================================
  // Speed control
  // ==========================================================
  // Roughly 7200 samples per second at 50 MHz
  localparam logic [DIV_W-1:0] SPEED_DEFAULT = 32'd6944;
  localparam logic [DIV_W-1:0] SPEED_STEP    = 32'd64;
  localparam logic [DIV_W-1:0] SPEED_MIN     = 32'd1024;
  localparam logic [DIV_W-1:0] SPEED_MAX     = 32'd20000;

  // Ten speed events per second
  localparam int REPEAT_CYCLES = 5_000_000;

  // ==========================================================
  // Types
  // ==========================================================
  typedef struct packed {
    logic [ADDR_W-1:0] start_addr;
    logic [7:0]        word_count;
    logic              silent;
  } phoneme_entry_t;

  typedef struct packed {
    logic              read;
    logic [ADDR_W-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [WORD_W-1:0] readdata;
  } flash_rsp_t;

  // Stored as a flash word, played as samples with element 0 in the low byte
  typedef union packed {
    logic [WORD_W-1:0]                               word;
    logic signed [SAMPLES_PER_WORD-1:0][SAMPLE_W-1:0] samples;
  } sample_word_u;

  localparam phoneme_entry_t PHONEME_TABLE [2**PHONEME_W] = '{
    '{start_addr: 23'd0,   word_count: 8'd4, silent: 1'b1},
    '{start_addr: 23'd16,  word_count: 8'd3, silent: 1'b0},
    '{start_addr: 23'd64,  word_count: 8'd6, silent: 1'b0},
    '{start_addr: 23'd200, word_count: 8'd2, silent: 1'b0}
  };

endpackage

`default_nettype wire
